/* cam_usb_vectors.txt */
# opcode argument: WR words, POP pops, IDLE cycles
# STAT argument is status bits {suspend, reset, online}
STAT 1
POP 16
WR 100
IDLE 4
POP 8
WR 156
IDLE 2
WR 600
IDLE 2
POP 512
IDLE 3
POP 512
IDLE 2
POP 300
STAT 6
WR 900
IDLE 2
POP 512
IDLE 2
POP 512
STAT 0

/* tb.f */
cam_usb_pkg.sv
pixel_byte_fifo.sv
usb_packet_gate.sv
heartbeat_div.sv
cam_usb_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_top.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run tb_top, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_top -f tb.f -o Vtb_top
	./obj_dir/Vtb_top > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_top.sv */
module tb_top;

  localparam int    depth_bytes = 2048;
  localparam int    half_period = 8;
  localparam int    tmo_margin  = 100;   // Extra cycles over the vector counts
  localparam string vec_file    = "cam_usb_vectors.txt";

  logic                             ulpi_clk;
  logic                             I_rst_n;
  logic                             pix_we;
  logic [cam_usb_pkg::pix_w-1:0]    pix_data;
  logic                             tx_pop;
  logic                             tx_act;
  logic                             usb_online;
  logic                             usb_rst;
  logic                             usb_suspend;
  logic [cam_usb_pkg::byte_w-1:0]   tx_dat;
  logic                             tx_cork;
  logic [cam_usb_pkg::txlen_w-1:0]  tx_len;
  logic [cam_usb_pkg::led_w-1:0]    led;
  logic                             heartbeat;

  logic [31:0] cur_op;        // Opcode text shown in error lines
  int          cur_rec;
  logic [31:0] op_q[$];
  int          arg_q[$];
  int          seed = 32'h24ac_e10e;
  int          data_errs;
  int          ctrl_errs;
  int          tb_errs = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;  // Zero until vectors are loaded

  tb_clock_gen #(.period(100), .rst_cycles(5)) u_clk (.clk_o(ulpi_clk), .rst_n_o(I_rst_n));

  cam_usb_top #(
    .fifo_depth_bytes(depth_bytes),
    .half_period     (half_period)
  ) UUT (
    .ulpi_clk(ulpi_clk), .I_rst_n(I_rst_n),
    .pix_we_i(pix_we), .pix_data_i(pix_data),
    .tx_pop_i(tx_pop), .tx_act_i(tx_act),
    .usb_online_i(usb_online), .usb_rst_i(usb_rst), .usb_suspend_i(usb_suspend),
    .tx_dat_o(tx_dat), .tx_cork_o(tx_cork), .tx_len_o(tx_len),
    .led_o(led), .heartbeat_o(heartbeat)
  );

  tb_checker #(
    .fifo_depth_bytes(depth_bytes),
    .half_period     (half_period)
  ) u_check (
    .ulpi_clk(ulpi_clk), .I_rst_n(I_rst_n),
    .pix_we_i(pix_we), .pix_data_i(pix_data), .tx_pop_i(tx_pop), .tx_act_i(tx_act),
    .status_i({usb_suspend, usb_rst, usb_online}),
    .tx_dat_i(tx_dat), .tx_cork_i(tx_cork), .tx_len_i(tx_len),
    .led_i(led), .heartbeat_i(heartbeat), .op_i(cur_op), .rec_i(cur_rec),
    .data_errs_o(data_errs), .ctrl_errs_o(ctrl_errs)
  );

  // ==============================
  // Stimulus tasks
  // ==============================
  task automatic step();
    @(posedge ulpi_clk);
    #10;  // Drive off the edge
  endtask

  task automatic write_words(input int n);
    int rnd;
    repeat (n) begin
      rnd      = $random(seed);
      pix_we   = 1'b1;
      pix_data = rnd[15:0];
      step();
    end
    pix_we = 1'b0;
  endtask

  task automatic run_packet(input int n);
    int waits;
    waits = 0;
    while (tx_cork && waits < 4) begin  // Short poll, then pops anyway
      step();
      waits++;
    end
    tx_act = 1'b1;
    step();
    tx_pop = 1'b1;
    repeat (n) step();
    tx_pop = 1'b0;
    tx_act = 1'b0;  // Falling act ends the packet
    step();
  endtask

  task automatic apply_status(input int v);
    usb_online  = v[0];
    usb_rst     = v[1];
    usb_suspend = v[2];
    step();
  endtask

  task automatic run_op(input logic [31:0] op, input int arg);
    if (op == {16'd0, "WR"}) write_words(arg);
    else if (op == {8'd0, "POP"}) run_packet(arg);
    else if (op == "IDLE") repeat (arg) step();
    else if (op == "STAT") apply_status(arg);
    else begin
      $display("Unknown opcode in vector record %0d", cur_rec);
      tb_errs++;
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          code;
    int          ch;
    int          arg;
    logic [31:0] tok;
    fd = $fopen(vec_file, "r");
    if (fd == 0) begin
      $display("Cannot open vector file %s", vec_file);
      tb_errs++;
      return;
    end
    while (!$feof(fd)) begin
      tok  = '0;
      code = $fscanf(fd, "%s", tok);
      if (code == 1 && tok == {24'd0, "#"}) begin
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin  // Skip comment to end of line
          ch = $fgetc(fd);
        end
      end else if (code == 1) begin
        code = $fscanf(fd, "%d", arg);
        if (code != 1) begin
          $display("Vector record %0d has no argument", op_q.size());
          tb_errs++;
        end else begin
          op_q.push_back(tok);
          arg_q.push_back(arg);
        end
      end
    end
    $fclose(fd);
  endtask

  // ==============================
  // Timeout
  // ==============================
  always @(posedge ulpi_clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout: run passed %0d cycles without finishing", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial begin
    pix_we      = 1'b0;
    pix_data    = '0;
    tx_pop      = 1'b0;
    tx_act      = 1'b0;
    usb_online  = 1'b0;
    usb_rst     = 1'b0;
    usb_suspend = 1'b0;
    cur_op      = {8'd0, "RST"};
    cur_rec     = 0;
    load_vectors();
    if (op_q.size() == 0) begin
      $display("No vector records loaded");
      tb_errs++;
    end
    foreach (op_q[i]) cycle_limit += (op_q[i] == "STAT") ? 1 : arg_q[i] + 8;  // 8 covers poll
    cycle_limit += tmo_margin;
    wait (I_rst_n === 1'b1);
    step();
    foreach (op_q[i]) begin
      cur_op  = op_q[i];
      cur_rec = i;
      run_op(op_q[i], arg_q[i]);
    end
    cur_op = {8'd0, "END"};
    repeat (4) step();  // Let the checker see the last edges
    $display("Errors: data %0d, control %0d, testbench %0d", data_errs, ctrl_errs, tb_errs);
    if (data_errs + ctrl_errs + tb_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* tb_checker.sv */
module tb_checker #(
  parameter int fifo_depth_bytes = 2048,
  parameter int half_period      = 8
) (
  input  logic                             ulpi_clk,
  input  logic                             I_rst_n,
  input  logic                             pix_we_i,
  input  logic [cam_usb_pkg::pix_w-1:0]    pix_data_i,
  input  logic                             tx_pop_i,
  input  logic                             tx_act_i,
  input  logic [2:0]                       status_i,     // {suspend, reset, online}
  input  logic [cam_usb_pkg::byte_w-1:0]   tx_dat_i,
  input  logic                             tx_cork_i,
  input  logic [cam_usb_pkg::txlen_w-1:0]  tx_len_i,
  input  logic [cam_usb_pkg::led_w-1:0]    led_i,
  input  logic                             heartbeat_i,
  input  logic [31:0]                      op_i,         // Opcode text of running record
  input  int                               rec_i,        // Record index
  output int                               data_errs_o,
  output int                               ctrl_errs_o
);

  localparam int lw = cam_usb_pkg::txlen_w;

  logic [cam_usb_pkg::byte_w-1:0] byte_q[$];  // Reference FIFO contents, head first
  cam_usb_pkg::gate_state_t       exp_state;
  logic [lw-1:0]                  exp_len;
  int                             beats;      // Cycles since reset release
  int                             data_errs = 0;
  int                             ctrl_errs = 0;

  assign data_errs_o = data_errs;
  assign ctrl_errs_o = ctrl_errs;

  task automatic report(input string what, input int exp_v, input int act_v, input bit is_data);
    $display("Error: test %0s rec %0d %0s expected %0h actual %0h",
             op_i, rec_i, what, exp_v, act_v);
    if (is_data) data_errs++;
    else ctrl_errs++;
  endtask

  // ==============================
  // Output compare
  // ==============================
  task automatic compare_outputs();
    logic       exp_cork;
    logic       exp_hb;
    logic [3:0] exp_led;
    exp_cork = !(exp_state == cam_usb_pkg::GATE_READY || exp_state == cam_usb_pkg::GATE_BUSY);
    exp_hb   = ((beats / half_period) % 2) == 1;  // One flip per half period
    exp_led  = {I_rst_n, ~status_i};               // Active low status
    if (tx_cork_i !== exp_cork) report("tx_cork", int'(exp_cork), int'(tx_cork_i), 1'b0);
    if (tx_len_i !== exp_len) report("tx_len", int'(exp_len), int'(tx_len_i), 1'b0);
    if (heartbeat_i !== exp_hb) report("heartbeat", int'(exp_hb), int'(heartbeat_i), 1'b0);
    if (led_i !== exp_led) report("led", int'(exp_led), int'(led_i), 1'b0);
    if (byte_q.size() > 0 && tx_dat_i !== byte_q[0]) begin
      report("tx_dat", int'(byte_q[0]), int'(tx_dat_i), 1'b1);  // Head byte order
    end
  endtask

  // ==============================
  // Reference model, next edge
  // ==============================
  task automatic advance_model();
    bit avail;
    bit pop_ok;
    bit wr_ok;
    avail  = byte_q.size() >= cam_usb_pkg::pkt_bytes;   // Full packet buffered
    pop_ok = tx_pop_i && exp_state == cam_usb_pkg::GATE_BUSY && byte_q.size() > 0 && avail;
    wr_ok  = pix_we_i && byte_q.size() < fifo_depth_bytes - 2;  // Dropped when almost full
    if (pop_ok) void'(byte_q.pop_front());
    if (wr_ok) begin
      byte_q.push_back(pix_data_i[7:0]);   // Low byte out first
      byte_q.push_back(pix_data_i[15:8]);
    end
    if (!tx_act_i) begin
      exp_len = lw'(cam_usb_pkg::pkt_bytes);
      if (exp_state == cam_usb_pkg::GATE_BUSY || !avail) exp_state = cam_usb_pkg::GATE_IDLE;
      else exp_state = cam_usb_pkg::GATE_READY;
    end else if (exp_state == cam_usb_pkg::GATE_READY) begin
      exp_state = cam_usb_pkg::GATE_BUSY;  // Controller took the offer
    end
    beats++;
  endtask

  // Inputs settle 10 after the rising edge, so negedge sees what the next edge sees
  always @(negedge ulpi_clk) begin
    if (!I_rst_n) begin
      byte_q.delete();
      exp_state = cam_usb_pkg::GATE_IDLE;
      exp_len   = '0;
      beats     = 0;
    end
    compare_outputs();
    if (I_rst_n) advance_model();
  end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int period     = 100,  // Clock period in time units
  parameter int rst_cycles = 5     // Rising edges with reset held
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;                  // Low from time zero
    repeat (rst_cycles) @(posedge clk_o);
    #(period / 10) rst_n_o = 1'b1;   // Released off the edge
  end

endmodule

/* cam_usb_top.sv */
module cam_usb_top #(
  parameter int fifo_depth_bytes = 4096,       // Pixel buffer bytes
  parameter int half_period      = 30_000_000  // Heartbeat half period, about 0.5 s at 60 MHz
) (
  input  logic                             ulpi_clk,       // 60 MHz from the PHY
  input  logic                             I_rst_n,
  // Camera side
  input  logic                             pix_we_i,
  input  logic [cam_usb_pkg::pix_w-1:0]    pix_data_i,
  // USB controller side
  input  logic                             tx_pop_i,
  input  logic                             tx_act_i,
  input  logic                             usb_online_i,
  input  logic                             usb_rst_i,
  input  logic                             usb_suspend_i,
  output logic [cam_usb_pkg::byte_w-1:0]   tx_dat_o,
  output logic                             tx_cork_o,
  output logic [cam_usb_pkg::txlen_w-1:0]  tx_len_o,
  // Board
  output logic [cam_usb_pkg::led_w-1:0]    led_o,          // Active low
  output logic                             heartbeat_o
);

  localparam int lvl_w = cam_usb_pkg::level_w(fifo_depth_bytes);

  logic [lvl_w-1:0] fifo_level;  // Bytes buffered
  logic             fifo_empty;
  logic             fifo_rd_en;  // Gated pop

  // ==============================
  // Pixel to byte buffer
  // ==============================
  pixel_byte_fifo #(
    .fifo_depth_bytes(fifo_depth_bytes)
  ) u_fifo (
    .ulpi_clk (ulpi_clk),
    .I_rst_n  (I_rst_n),
    .wr_en_i  (pix_we_i),    // Gated inside when almost full
    .wr_data_i(pix_data_i),
    .rd_en_i  (fifo_rd_en),
    .rd_data_o(tx_dat_o),    // Head byte straight to controller
    .level_o  (fifo_level),
    .empty_o  (fifo_empty)
  );

  // ==============================
  // Packet gate
  // ==============================
  usb_packet_gate #(
    .fifo_depth_bytes(fifo_depth_bytes)
  ) u_gate (
    .ulpi_clk (ulpi_clk),
    .I_rst_n  (I_rst_n),
    .level_i  (fifo_level),
    .empty_i  (fifo_empty),
    .tx_pop_i (tx_pop_i),
    .tx_act_i (tx_act_i),
    .rd_en_o  (fifo_rd_en),
    .tx_cork_o(tx_cork_o),
    .tx_len_o (tx_len_o)
  );

  heartbeat_div #(
    .half_period(half_period)
  ) u_beat (
    .ulpi_clk(ulpi_clk),
    .I_rst_n (I_rst_n),
    .beat_o  (heartbeat_o)
  );

  // ==============================
  // Status LEDs
  // ==============================
  assign led_o[0] = ~usb_online_i;   // Lit when enumerated
  assign led_o[1] = ~usb_rst_i;      // Lit during bus reset
  assign led_o[2] = ~usb_suspend_i;  // Lit when suspended
  assign led_o[3] = I_rst_n;         // Lit while held in reset

endmodule

/* heartbeat_div.sv */
module heartbeat_div #(
  parameter int half_period = 30_000_000  // Clocks between toggles
) (
  input  logic ulpi_clk,
  input  logic I_rst_n,
  output logic beat_o  // Slow toggle, clock alive
);

  localparam int cnt_w = (half_period > 1) ? $clog2(half_period) : 1;

  logic [cnt_w-1:0] cnt_q;
  logic             wrap;  // Last cycle of a half period

  assign wrap = (cnt_q == cnt_w'(half_period - 1));

  // ==============================
  // Divider
  // ==============================
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      cnt_q  <= '0;
      beat_o <= 1'b0;
    end else if (wrap) begin
      cnt_q  <= '0;
      beat_o <= ~beat_o;  // Flip once per half period
    end else begin
      cnt_q  <= cnt_q + 1'b1;
    end
  end

endmodule

/* usb_packet_gate.sv */
module usb_packet_gate #(
  parameter  int fifo_depth_bytes = 4096,  // Sets level_i width
  localparam int lvl_w = cam_usb_pkg::level_w(fifo_depth_bytes)
) (
  input  logic                             ulpi_clk,
  input  logic                             I_rst_n,
  input  logic [lvl_w-1:0]                 level_i,    // FIFO bytes buffered
  input  logic                             empty_i,
  input  logic                             tx_pop_i,   // Controller wants a byte
  input  logic                             tx_act_i,   // Controller packet active
  output logic                             rd_en_o,    // FIFO pop
  output logic                             tx_cork_o,  // High holds the controller off
  output logic [cam_usb_pkg::txlen_w-1:0]  tx_len_o    // Packet length to send
);

  localparam int lw = cam_usb_pkg::txlen_w;

  cam_usb_pkg::gate_state_t state_q;
  cam_usb_pkg::gate_state_t state_d;
  logic [lw-1:0]            len_q;
  logic                     pkt_avail;  // A whole packet is buffered

  assign pkt_avail = (level_i >= lvl_w'(cam_usb_pkg::pkt_bytes));

  // ==============================
  // Gate FSM
  // ==============================
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      cam_usb_pkg::GATE_IDLE: begin
        if (!tx_act_i && pkt_avail) begin
          state_d = cam_usb_pkg::GATE_READY;  // Sample readiness while idle
        end
      end
      cam_usb_pkg::GATE_READY: begin
        if (tx_act_i) begin
          state_d = cam_usb_pkg::GATE_BUSY;   // Controller took the packet
        end else if (!pkt_avail) begin
          state_d = cam_usb_pkg::GATE_IDLE;
        end
      end
      cam_usb_pkg::GATE_BUSY: begin
        if (!tx_act_i) begin
          state_d = cam_usb_pkg::GATE_IDLE;   // Packet done
        end
      end
      default: state_d = cam_usb_pkg::GATE_IDLE;
    endcase
  end

  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      state_q <= cam_usb_pkg::GATE_IDLE;
      len_q   <= '0;
    end else begin
      state_q <= state_d;
      if (!tx_act_i) begin
        len_q <= lw'(cam_usb_pkg::pkt_bytes);  // Fixed size bulk packets
      end
    end
  end

  // Uncorked only while a packet is offered or in flight
  assign tx_cork_o = !(state_q inside {cam_usb_pkg::GATE_READY, cam_usb_pkg::GATE_BUSY});
  assign tx_len_o  = len_q;

  // Honor pops only mid-packet with a full packet still buffered
  assign rd_en_o = tx_pop_i && (state_q == cam_usb_pkg::GATE_BUSY) && !empty_i && pkt_avail;

  // ==============================
  // Checks
  // ==============================
  // Offered packet stays fully buffered until the controller takes it
  a_ready_has_pkt: assert property (
    @(posedge ulpi_clk) disable iff (!I_rst_n)
    (state_q == cam_usb_pkg::GATE_READY) |-> pkt_avail
  );

  // Controller pops only inside an active packet
  a_pop_in_pkt: assert property (
    @(posedge ulpi_clk) disable iff (!I_rst_n)
    tx_pop_i |-> tx_act_i
  );

endmodule

/* pixel_byte_fifo.sv */
module pixel_byte_fifo #(
  parameter  int fifo_depth_bytes = 4096,  // Total capacity in bytes, power of two
  localparam int lvl_w = cam_usb_pkg::level_w(fifo_depth_bytes)
) (
  input  logic                            ulpi_clk,
  input  logic                            I_rst_n,
  input  logic                            wr_en_i,    // Pixel word strobe
  input  logic [cam_usb_pkg::pix_w-1:0]   wr_data_i,  // Pixel word
  input  logic                            rd_en_i,    // Byte pop
  output logic [cam_usb_pkg::byte_w-1:0]  rd_data_o,  // Head byte, fall-through
  output logic [lvl_w-1:0]                level_o,    // Fill level in bytes
  output logic                            empty_o
);

  localparam int pw      = cam_usb_pkg::pix_w;
  localparam int bw      = cam_usb_pkg::byte_w;
  localparam int words   = fifo_depth_bytes / 2;       // Two bytes per stored word
  localparam int waddr_w = $clog2(words);
  localparam int raddr_w = $clog2(fifo_depth_bytes);  // Byte granular read side
  localparam int af_lvl  = fifo_depth_bytes - 2;      // Almost full, room for one word

  // ==============================
  // Storage and pointers
  // ==============================
  logic [pw-1:0]      mem_q [words];  // Word RAM, low byte read first
  logic [waddr_w-1:0] wptr_q;         // Next word slot
  logic [raddr_w-1:0] rptr_q;         // Head byte address
  logic [lvl_w-1:0]   level_q;        // Buffered bytes
  logic               wr_ok;          // Word accepted this edge
  logic               rd_ok;          // Byte removed this edge
  logic [pw-1:0]      head_word;      // Word holding the head byte

  // Drop words once almost full, no back-pressure to camera
  assign wr_ok = wr_en_i && (level_q < lvl_w'(af_lvl));
  assign rd_ok = rd_en_i && !empty_o;  // Ignore pops on empty

  assign empty_o = (level_q == '0);
  assign level_o = level_q;

  // Upper read address bits select the word, bit 0 picks the byte
  assign head_word = mem_q[rptr_q[raddr_w-1:1]];
  assign rd_data_o = rptr_q[0] ? head_word[pw-1:bw] : head_word[bw-1:0];

  // Payload RAM
  always_ff @(posedge ulpi_clk) begin
    if (wr_ok) begin
      mem_q[wptr_q] <= wr_data_i;
    end
  end

  // ==============================
  // Pointer and level control
  // ==============================
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else begin
      if (wr_ok) begin
        wptr_q <= wptr_q + 1'b1;  // Wraps at depth
      end
      if (rd_ok) begin
        rptr_q <= rptr_q + 1'b1;
      end
      unique case ({wr_ok, rd_ok})
        2'b10:   level_q <= level_q + lvl_w'(2);  // Word in
        2'b01:   level_q <= level_q - lvl_w'(1);  // Byte out
        2'b11:   level_q <= level_q + lvl_w'(1);  // Both, net +1
        default: level_q <= level_q;
      endcase
    end
  end

  // ==============================
  // Checks
  // ==============================
  // Pop logic in the gate must never fire on an empty buffer
  a_no_rd_empty: assert property (
    @(posedge ulpi_clk) disable iff (!I_rst_n)
    rd_en_i |-> !empty_o
  );

  // Almost-full gating keeps the level within capacity over time
  a_level_max: assert property (
    @(posedge ulpi_clk) disable iff (!I_rst_n)
    level_q <= lvl_w'(fifo_depth_bytes)
  );

endmodule

/* cam_usb_pkg.sv */
package cam_usb_pkg;

  // ==============================
  // Data path widths
  // ==============================
  localparam int pix_w   = 16;  // Camera pixel word
  localparam int byte_w  = 8;   // USB bulk data byte
  localparam int txlen_w = 12;  // Controller length field
  localparam int led_w   = 4;   // Board status LEDs

  // ==============================
  // USB packet framing
  // ==============================
  localparam int pkt_bytes = 512;  // High speed bulk max packet

  // Packet gate FSM states
  typedef enum logic [1:0] {
    GATE_IDLE,   // Corked, waiting for a full packet
    GATE_READY,  // Full packet buffered, cork released
    GATE_BUSY    // Controller is pulling bytes
  } gate_state_t;

  // Byte level counter width for a given FIFO depth
  // Needs to hold the value depth itself, hence the +1
  function automatic int level_w(input int depth);
    return $clog2(depth + 1);
  endfunction

endpackage
